// ==== falafel_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module falafel_assert (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  mem_req_val_i,
  input  logic                  mem_req_rdy_i,
  input  falafel_pkg::mem_req_t mem_req_i,
  input  logic                  alloc_empty_i,
  input  logic                  alloc_read_i,
  input  logic                  free_empty_i,
  input  logic                  free_read_i,
  input  logic                  resp_full_i,
  input  logic                  resp_write_i
);

  int error_count = 0;

  // a stalled request keeps its payload
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_val_i && !mem_req_rdy_i |=> mem_req_val_i && $stable(mem_req_i))
    else begin
      $error("memory request dropped or changed before it was accepted");
      error_count++;
    end

  a_resp_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_write_i |-> !resp_full_i)
    else begin
      $error("write to a full response FIFO");
      error_count++;
    end

  a_alloc_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_read_i |-> !alloc_empty_i)
    else begin
      $error("read from an empty allocation FIFO");
      error_count++;
    end

  a_free_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    free_read_i |-> !free_empty_i)
    else begin
      $error("read from an empty free FIFO");
      error_count++;
    end

  a_one_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alloc_read_i && free_read_i))
    else begin
      $error("both input FIFOs read in the same cycle");
      error_count++;
    end

endmodule

bind falafel_top falafel_assert i_falafel_assert (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .mem_req_val_i (mem_req_val_o),
  .mem_req_rdy_i (mem_req_rdy_i),
  .mem_req_i     (mem_req_o),
  .alloc_empty_i (alloc_fifo_empty_i),
  .alloc_read_i  (alloc_fifo_read_o),
  .free_empty_i  (free_fifo_empty_i),
  .free_read_i   (free_fifo_read_o),
  .resp_full_i   (resp_fifo_full_i),
  .resp_write_i  (resp_fifo_write_o)
);

`default_nettype wire

// ==== falafel_block_parser.sv ====
`timescale 1ns/10ps
`default_nettype none

module falafel_block_parser (
  input  falafel_pkg::free_block_t block_i,
  input  falafel_pkg::word_t       requested_size_i,
  output logic                     is_null_o,
  output logic                     is_big_enough_o,
  output logic                     split_o,
  output falafel_pkg::free_block_t remainder_o
);
  import falafel_pkg::*;

  word_t leftover;  // only meaningful when the block fits

  assign leftover = block_i.size - requested_size_i;

  assign is_null_o       = (block_i.next_ptr == NULL_PTR);
  assign is_big_enough_o = (block_i.size >= requested_size_i);

  // remainder must hold its own header plus a minimum payload
  assign split_o = is_big_enough_o &&
                   (leftover >= MIN_ALLOC_SIZE + BLOCK_HEADER_SIZE);

  assign remainder_o = '{
    size:     leftover - BLOCK_HEADER_SIZE,
    next_ptr: block_i.next_ptr
  };

endmodule

`default_nettype wire

// ==== falafel_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module falafel_core (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  falafel_pkg::word_t       free_list_ptr_i,

  input  logic                     alloc_fifo_empty_i,
  output logic                     alloc_fifo_read_o,
  input  falafel_pkg::word_t       alloc_fifo_dout_i,
  input  logic                     free_fifo_empty_i,
  output logic                     free_fifo_read_o,
  input  falafel_pkg::word_t       free_fifo_dout_i,
  input  logic                     resp_fifo_full_i,
  output logic                     resp_fifo_write_o,
  output falafel_pkg::word_t       resp_fifo_din_o,

  output logic                     lsu_req_val_o,
  input  logic                     lsu_req_rdy_i,
  output falafel_pkg::lsu_req_t    lsu_req_o,
  input  logic                     lsu_rsp_val_i,
  output logic                     lsu_rsp_rdy_o,
  input  falafel_pkg::word_t       lsu_rsp_word_i,
  input  falafel_pkg::free_block_t lsu_rsp_block_i
);
  import falafel_pkg::*;

  typedef enum logic [4:0] {
    S_INIT, S_IDLE,
    S_LOAD_HEAD, S_WAIT_HEAD, S_LOAD_BLOCK, S_WAIT_BLOCK, S_PROCESS,
    S_STORE_REM, S_WAIT_REM, S_STORE_SIZE, S_WAIT_SIZE,
    S_STORE_NEXT, S_WAIT_NEXT, S_LINK, S_WAIT_LINK,
    S_RESPONSE
  } state_e;

  state_e      state_q, state_d;
  logic        free_op_q, free_op_d;  // list walk serves a free
  word_t       size_q, size_d;
  word_t       result_q, result_d;
  word_t       free_ptr_q, free_ptr_d;  // header of the freed block
  word_t       cur_ptr_q, cur_ptr_d;
  word_t       prev_ptr_q, prev_ptr_d;
  word_t       next_ptr_q, next_ptr_d;
  free_block_t block_q, block_d;

  logic        bp_is_null;
  logic        bp_is_big_enough;
  logic        bp_split;
  free_block_t bp_remainder;
  word_t       rem_ptr;

  falafel_block_parser i_block_parser (
    .block_i          (block_q),
    .requested_size_i (size_q),
    .is_null_o        (bp_is_null),
    .is_big_enough_o  (bp_is_big_enough),
    .split_o          (bp_split),
    .remainder_o      (bp_remainder)
  );

  assign rem_ptr         = cur_ptr_q + WORD_SIZE + size_q;
  assign resp_fifo_din_o = result_q;

  always_comb begin
    state_d    = state_q;
    free_op_d  = free_op_q;
    size_d     = size_q;
    result_d   = result_q;
    free_ptr_d = free_ptr_q;
    cur_ptr_d  = cur_ptr_q;
    prev_ptr_d = prev_ptr_q;
    next_ptr_d = next_ptr_q;
    block_d    = block_q;

    alloc_fifo_read_o = 1'b0;
    free_fifo_read_o  = 1'b0;
    resp_fifo_write_o = 1'b0;
    lsu_req_val_o     = 1'b0;
    lsu_rsp_rdy_o     = 1'b0;
    lsu_req_o         = '0;

    unique case (state_q)
      S_INIT: state_d = S_IDLE;
      S_IDLE: begin
        if (!alloc_fifo_empty_i) begin
          alloc_fifo_read_o = 1'b1;
          free_op_d         = 1'b0;
          if (alloc_fifo_dout_i == '0) begin
            result_d = NULL_PTR;
            state_d  = S_RESPONSE;
          end else begin
            size_d  = align_size(alloc_fifo_dout_i);
            state_d = S_LOAD_HEAD;
          end
        end else if (!free_fifo_empty_i) begin
          free_fifo_read_o = 1'b1;
          free_op_d        = 1'b1;
          free_ptr_d       = free_fifo_dout_i - WORD_SIZE;
          state_d          = S_LOAD_HEAD;
        end
      end
      S_LOAD_HEAD: begin
        lsu_req_val_o  = 1'b1;
        lsu_req_o.op   = LSU_LOAD_WORD;
        lsu_req_o.addr = free_list_ptr_i;
        if (lsu_req_rdy_i) begin
          cur_ptr_d = free_list_ptr_i - WORD_SIZE;  // head word acts as a next field
          state_d   = S_WAIT_HEAD;
        end
      end
      S_WAIT_HEAD: begin
        lsu_rsp_rdy_o = 1'b1;
        if (lsu_rsp_val_i) begin
          block_d = '{size: NULL_PTR, next_ptr: lsu_rsp_word_i};  // zero size never fits
          state_d = S_PROCESS;
        end
      end
      S_LOAD_BLOCK: begin
        lsu_req_val_o  = 1'b1;
        lsu_req_o.op   = LSU_LOAD_BLOCK;
        lsu_req_o.addr = next_ptr_q;
        if (lsu_req_rdy_i) begin
          prev_ptr_d = cur_ptr_q;
          cur_ptr_d  = next_ptr_q;
          state_d    = S_WAIT_BLOCK;
        end
      end
      S_WAIT_BLOCK: begin
        lsu_rsp_rdy_o = 1'b1;
        if (lsu_rsp_val_i) begin
          block_d = lsu_rsp_block_i;
          state_d = S_PROCESS;
        end
      end
      S_PROCESS: begin
        next_ptr_d = block_q.next_ptr;
        if (free_op_q) begin
          // stop ahead of the first block above the freed one
          if (bp_is_null || (block_q.next_ptr > free_ptr_q)) begin
            prev_ptr_d = cur_ptr_q;
            state_d    = S_STORE_NEXT;
          end else begin
            state_d = S_LOAD_BLOCK;
          end
        end else if (bp_is_big_enough) begin
          result_d = cur_ptr_q + WORD_SIZE;
          state_d  = bp_split ? S_STORE_REM : S_LINK;
        end else if (bp_is_null) begin
          result_d = ERR_NOMEM;
          state_d  = S_RESPONSE;
        end else begin
          state_d = S_LOAD_BLOCK;
        end
      end
      S_STORE_REM: begin
        lsu_req_val_o   = 1'b1;
        lsu_req_o.op    = LSU_STORE_BLOCK;
        lsu_req_o.addr  = rem_ptr;
        lsu_req_o.block = bp_remainder;
        if (lsu_req_rdy_i) begin
          next_ptr_d = rem_ptr;  // prev gets linked to the remainder
          state_d    = S_WAIT_REM;
        end
      end
      S_WAIT_REM: begin
        lsu_rsp_rdy_o = 1'b1;
        if (lsu_rsp_val_i) begin
          state_d = S_STORE_SIZE;
        end
      end
      S_STORE_SIZE: begin
        lsu_req_val_o  = 1'b1;
        lsu_req_o.op   = LSU_STORE_WORD;
        lsu_req_o.addr = cur_ptr_q;
        lsu_req_o.word = size_q;
        if (lsu_req_rdy_i) begin
          state_d = S_WAIT_SIZE;
        end
      end
      S_STORE_NEXT: begin
        lsu_req_val_o  = 1'b1;
        lsu_req_o.op   = LSU_STORE_WORD;
        lsu_req_o.addr = free_ptr_q + BLOCK_NEXT_PTR_OFFSET;
        lsu_req_o.word = next_ptr_q;
        if (lsu_req_rdy_i) begin
          next_ptr_d = free_ptr_q;
          state_d    = S_WAIT_NEXT;
        end
      end
      S_WAIT_SIZE, S_WAIT_NEXT: begin
        lsu_rsp_rdy_o = 1'b1;
        if (lsu_rsp_val_i) begin
          state_d = S_LINK;
        end
      end
      S_LINK: begin
        lsu_req_val_o  = 1'b1;
        lsu_req_o.op   = LSU_STORE_WORD;
        lsu_req_o.addr = prev_ptr_q + BLOCK_NEXT_PTR_OFFSET;
        lsu_req_o.word = next_ptr_q;
        if (lsu_req_rdy_i) begin
          state_d = S_WAIT_LINK;
        end
      end
      S_WAIT_LINK: begin
        lsu_rsp_rdy_o = 1'b1;
        if (lsu_rsp_val_i) begin
          state_d = free_op_q ? S_IDLE : S_RESPONSE;  // no answer for a free
        end
      end
      S_RESPONSE: begin
        if (!resp_fifo_full_i) begin
          resp_fifo_write_o = 1'b1;
          state_d           = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= S_INIT;
      free_op_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      free_op_q <= free_op_d;
    end
  end

  always_ff @(posedge clk_i) begin
    size_q     <= size_d;
    result_q   <= result_d;
    free_ptr_q <= free_ptr_d;
    cur_ptr_q  <= cur_ptr_d;
    prev_ptr_q <= prev_ptr_d;
    next_ptr_q <= next_ptr_d;
    block_q    <= block_d;
  end

endmodule

`default_nettype wire

// ==== falafel_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module falafel_lsu (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     req_val_i,
  output logic                     req_rdy_o,
  input  falafel_pkg::lsu_req_t    req_i,

  output logic                     rsp_val_o,
  input  logic                     rsp_rdy_i,
  output falafel_pkg::word_t       rsp_word_o,
  output falafel_pkg::free_block_t rsp_block_o,

  output logic                     mem_req_val_o,
  input  logic                     mem_req_rdy_i,
  output falafel_pkg::mem_req_t    mem_req_o,
  input  logic                     mem_rsp_val_i,
  output logic                     mem_rsp_rdy_o,
  input  falafel_pkg::word_t       mem_rsp_data_i
);
  import falafel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_RSP
  } state_e;

  state_e      state_q;
  lsu_req_t    op_q;
  logic        second_q;  // on the upper word of a block op
  free_block_t data_q;
  logic        is_block;
  logic        is_store;
  logic        last_word;

  assign is_block  = (op_q.op == LSU_LOAD_BLOCK) || (op_q.op == LSU_STORE_BLOCK);
  assign is_store  = (op_q.op == LSU_STORE_WORD) || (op_q.op == LSU_STORE_BLOCK);
  assign last_word = !is_block || second_q;

  assign req_rdy_o     = (state_q == S_IDLE);
  assign mem_req_val_o = (state_q == S_REQ);
  assign mem_rsp_rdy_o = (state_q == S_WAIT);

  always_comb begin
    mem_req_o.is_write = is_store;
    mem_req_o.addr     = second_q ? op_q.addr + WORD_SIZE : op_q.addr;
    if (op_q.op == LSU_STORE_BLOCK) begin
      mem_req_o.data = second_q ? op_q.block.next_ptr : op_q.block.size;
    end else begin
      mem_req_o.data = op_q.word;
    end
  end

  // last response goes straight through, held only if the core stalls
  assign rsp_val_o   = (state_q == S_RSP) ||
                       ((state_q == S_WAIT) && mem_rsp_val_i && last_word);
  assign rsp_word_o  = (state_q == S_RSP) ? data_q.next_ptr : mem_rsp_data_i;
  assign rsp_block_o = '{size: data_q.size, next_ptr: rsp_word_o};

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q  <= S_IDLE;
      second_q <= 1'b0;
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (req_val_i) begin
            state_q  <= S_REQ;
            second_q <= 1'b0;
          end
        end
        S_REQ: begin
          if (mem_req_rdy_i) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (mem_rsp_val_i) begin
            if (!last_word) begin
              second_q <= 1'b1;
              state_q  <= S_REQ;
            end else begin
              state_q <= rsp_rdy_i ? S_IDLE : S_RSP;
            end
          end
        end
        S_RSP: begin
          if (rsp_rdy_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == S_IDLE) && req_val_i) begin
      op_q <= req_i;
    end
    if ((state_q == S_WAIT) && mem_rsp_val_i) begin
      if (last_word) begin
        data_q.next_ptr <= mem_rsp_data_i;
      end else begin
        data_q.size <= mem_rsp_data_i;  // lower word of a block
      end
    end
  end

endmodule

`default_nettype wire

// ==== falafel_pkg.sv ====
`default_nettype none

package falafel_pkg;

  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0] word_t;

  localparam word_t WORD_SIZE             = 4;
  localparam word_t BLOCK_HEADER_SIZE     = 4;  // size word stays with the allocation
  localparam word_t BLOCK_NEXT_PTR_OFFSET = 4;
  localparam word_t BLOCK_ALIGNMENT       = 8;
  localparam word_t MIN_ALLOC_SIZE        = 8;

  localparam word_t NULL_PTR  = '0;
  localparam word_t ERR_NOMEM = '1;

  // layout in memory: size word first, next pointer one word above
  typedef struct packed {
    word_t size;      // payload bytes
    word_t next_ptr;
  } free_block_t;

  typedef enum logic [1:0] {
    LSU_LOAD_WORD,
    LSU_LOAD_BLOCK,
    LSU_STORE_WORD,
    LSU_STORE_BLOCK
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e     op;
    word_t       addr;
    word_t       word;   // store data, word ops
    free_block_t block;  // store data, block ops
  } lsu_req_t;

  typedef struct packed {
    logic  is_write;
    word_t addr;
    word_t data;
  } mem_req_t;

  // round up to the block alignment
  function automatic word_t align_size(word_t size);
    return (size + BLOCK_ALIGNMENT - 1) & ~(BLOCK_ALIGNMENT - 1);
  endfunction

endpackage

`default_nettype wire

// ==== falafel_tests.txt ====
# name op operand expected, all hex
# alloc operand is the size, free operand is the payload pointer, expected unused for free
zero_size      alloc 00000000 00000000
first_alloc    alloc 00000014 00000104
second_alloc   alloc 00000014 00000120
free_first     free  00000104 00000000
realloc_first  alloc 00000014 00000104
split_16       alloc 0000000d 0000013c
split_8        alloc 00000005 00000150
free_upper     free  00000150 00000000
free_lower     free  0000013c 00000000
no_split_low   alloc 00000008 0000013c
exact_upper    alloc 00000008 00000150
too_large      alloc 00001000 ffffffff
free_head      free  00000104 00000000
free_walk      free  00000120 00000000
refill_head    alloc 00000018 00000104
refill_walk    alloc 00000018 00000120
take_rest      alloc 000003a8 0000015c
empty_list     alloc 00000008 ffffffff

// ==== falafel_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module falafel_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  falafel_pkg::word_t    free_list_ptr_i,

  input  logic                  alloc_fifo_empty_i,
  output logic                  alloc_fifo_read_o,
  input  falafel_pkg::word_t    alloc_fifo_dout_i,
  input  logic                  free_fifo_empty_i,
  output logic                  free_fifo_read_o,
  input  falafel_pkg::word_t    free_fifo_dout_i,
  input  logic                  resp_fifo_full_i,
  output logic                  resp_fifo_write_o,
  output falafel_pkg::word_t    resp_fifo_din_o,

  output logic                  mem_req_val_o,
  input  logic                  mem_req_rdy_i,
  output falafel_pkg::mem_req_t mem_req_o,
  input  logic                  mem_rsp_val_i,
  output logic                  mem_rsp_rdy_o,
  input  falafel_pkg::word_t    mem_rsp_data_i
);
  import falafel_pkg::*;

  logic        lsu_req_val;
  logic        lsu_req_rdy;
  lsu_req_t    lsu_req;
  logic        lsu_rsp_val;
  logic        lsu_rsp_rdy;
  word_t       lsu_rsp_word;
  free_block_t lsu_rsp_block;

  falafel_core i_core (
    .clk_i,
    .rst_ni,
    .free_list_ptr_i,
    .alloc_fifo_empty_i,
    .alloc_fifo_read_o,
    .alloc_fifo_dout_i,
    .free_fifo_empty_i,
    .free_fifo_read_o,
    .free_fifo_dout_i,
    .resp_fifo_full_i,
    .resp_fifo_write_o,
    .resp_fifo_din_o,
    .lsu_req_val_o   (lsu_req_val),
    .lsu_req_rdy_i   (lsu_req_rdy),
    .lsu_req_o       (lsu_req),
    .lsu_rsp_val_i   (lsu_rsp_val),
    .lsu_rsp_rdy_o   (lsu_rsp_rdy),
    .lsu_rsp_word_i  (lsu_rsp_word),
    .lsu_rsp_block_i (lsu_rsp_block)
  );

  falafel_lsu i_lsu (
    .clk_i,
    .rst_ni,
    .req_val_i   (lsu_req_val),
    .req_rdy_o   (lsu_req_rdy),
    .req_i       (lsu_req),
    .rsp_val_o   (lsu_rsp_val),
    .rsp_rdy_i   (lsu_rsp_rdy),
    .rsp_word_o  (lsu_rsp_word),
    .rsp_block_o (lsu_rsp_block),
    .mem_req_val_o,
    .mem_req_rdy_i,
    .mem_req_o,
    .mem_rsp_val_i,
    .mem_rsp_rdy_o,
    .mem_rsp_data_i
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_falafel.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_falafel;
  import falafel_pkg::*;

  localparam word_t HEAD_ADDR      = 32'h10;
  localparam int    TIMEOUT_CYCLES = 500;
  localparam int    STALL_CYCLES   = 6;

  logic     clk;
  logic     rst_n;
  word_t    free_list_ptr;
  logic     alloc_fifo_empty;
  logic     alloc_fifo_read;
  word_t    alloc_fifo_dout;
  logic     free_fifo_empty;
  logic     free_fifo_read;
  word_t    free_fifo_dout;
  logic     resp_fifo_full;
  logic     resp_fifo_write;
  word_t    resp_fifo_din;
  logic     mem_req_val;
  logic     mem_req_rdy;
  mem_req_t mem_req;
  logic     mem_rsp_val;
  logic     mem_rsp_rdy;
  word_t    mem_rsp_data;

  word_t    resp_q [$];
  int       alloc_reads = 0;
  int       free_reads  = 0;
  int       n_pass      = 0;
  int       n_fail      = 0;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  falafel_top falafel_top_inst (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .free_list_ptr_i    (free_list_ptr),
    .alloc_fifo_empty_i (alloc_fifo_empty),
    .alloc_fifo_read_o  (alloc_fifo_read),
    .alloc_fifo_dout_i  (alloc_fifo_dout),
    .free_fifo_empty_i  (free_fifo_empty),
    .free_fifo_read_o   (free_fifo_read),
    .free_fifo_dout_i   (free_fifo_dout),
    .resp_fifo_full_i   (resp_fifo_full),
    .resp_fifo_write_o  (resp_fifo_write),
    .resp_fifo_din_o    (resp_fifo_din),
    .mem_req_val_o      (mem_req_val),
    .mem_req_rdy_i      (mem_req_rdy),
    .mem_req_o          (mem_req),
    .mem_rsp_val_i      (mem_rsp_val),
    .mem_rsp_rdy_o      (mem_rsp_rdy),
    .mem_rsp_data_i     (mem_rsp_data)
  );

  tb_falafel_mem #(.HEAD_ADDR(HEAD_ADDR)) i_mem (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_val_i  (mem_req_val),
    .req_rdy_o  (mem_req_rdy),
    .req_i      (mem_req),
    .rsp_val_o  (mem_rsp_val),
    .rsp_rdy_i  (mem_rsp_rdy),
    .rsp_data_o (mem_rsp_data)
  );

  // FIFO side of the handshakes as flops would see them
  always @(posedge clk) begin
    if (alloc_fifo_read) alloc_reads <= alloc_reads + 1;
    if (free_fifo_read) free_reads <= free_reads + 1;
    if (resp_fifo_write) resp_q.push_back(resp_fifo_din);
  end

  // one-entry input FIFO emptied once the DUT has read it
  task automatic push_request(input logic is_free, input word_t value, output logic taken);
    int start;
    start = is_free ? free_reads : alloc_reads;
    taken = 1'b0;
    if (is_free) begin
      free_fifo_dout  = value;
      free_fifo_empty = 1'b0;
    end else begin
      alloc_fifo_dout  = value;
      alloc_fifo_empty = 1'b0;
    end
    for (int i = 0; i < TIMEOUT_CYCLES && !taken; i++) begin
      @(negedge clk);
      taken = ((is_free ? free_reads : alloc_reads) != start);
    end
    alloc_fifo_empty = 1'b1;
    free_fifo_empty  = 1'b1;
  endtask

  task automatic wait_response(output word_t value, output logic got);
    got   = 1'b0;
    value = '0;
    for (int i = 0; i < TIMEOUT_CYCLES && !got; i++) begin
      resp_fifo_full = (i < STALL_CYCLES);  // response FIFO full for a while
      @(negedge clk);
      got = (resp_q.size() != 0);
    end
    resp_fifo_full = 1'b0;
    if (got) value = resp_q.pop_front();
  endtask

  task automatic check_result(input string name, input word_t expected, input word_t actual);
    assert (actual == expected) begin
      n_pass++;
      $display("pass %s: got %h", name, actual);
    end else begin
      n_fail++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  initial begin
    int    fd;
    int    cycles;
    string line;
    string name;
    string op;
    word_t operand;
    word_t expected;
    word_t actual;
    logic  ok;
    logic  timed_out;

    free_list_ptr    = HEAD_ADDR;
    alloc_fifo_empty = 1'b1;
    alloc_fifo_dout  = '0;
    free_fifo_empty  = 1'b1;
    free_fifo_dout   = '0;
    resp_fifo_full   = 1'b0;
    timed_out        = 1'b0;

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      n_fail++;
      $display("reset was never released");
    end

    fd = $fopen("falafel_tests.txt", "r");
    if (fd == 0) begin
      n_fail++;
      $display("cannot open falafel_tests.txt");
    end
    while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%s %s %h %h", name, op, operand, expected) != 4) begin
        n_fail++;
        $display("malformed line in falafel_tests.txt: %s", line);
        continue;
      end
      if (op == "free") begin
        push_request(1'b1, operand, ok);
        if (ok) begin
          n_pass++;
          $display("pass %s: pointer %h taken", name, operand);
        end else begin
          timed_out = 1'b1;
          n_fail++;
          $display("Timeout in %s: the free request was never read", name);
        end
      end else if (op == "alloc") begin
        push_request(1'b0, operand, ok);
        if (ok) wait_response(actual, ok);
        if (ok) begin
          check_result(name, expected, actual);
        end else begin
          timed_out = 1'b1;
          n_fail++;
          $display("Timeout in %s: no allocation result arrived", name);
        end
      end else begin
        n_fail++;
        $display("unknown operation %s in test %s", op, name);
      end
    end
    if (fd != 0) $fclose(fd);

    // frees must not answer
    assert (resp_q.size() == 0) else begin
      n_fail++;
      $display("%0d unexpected responses were written", resp_q.size());
    end

    $display("%0d passed, %0d failed, %0d assertion errors", n_pass, n_fail,
             falafel_top_inst.i_falafel_assert.error_count);
    if (n_fail == 0 && falafel_top_inst.i_falafel_assert.error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_falafel_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_falafel_mem #(
  parameter falafel_pkg::word_t HEAD_ADDR = 32'h10,
  parameter falafel_pkg::word_t HEAP_ADDR = 32'h100,
  parameter falafel_pkg::word_t HEAP_SIZE = 32'h400
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_val_i,
  output logic                  req_rdy_o,
  input  falafel_pkg::mem_req_t req_i,
  output logic                  rsp_val_o,
  input  logic                  rsp_rdy_i,
  output falafel_pkg::word_t    rsp_data_o
);
  import falafel_pkg::*;

  localparam int WORDS = 1024;

  word_t      mem [WORDS];
  integer     seed = 32'h57dae7bb;
  logic       pending_q;
  logic       stall_q;   // refuses the next request
  logic [1:0] delay_q;   // cycles left before the response
  word_t      rdata_q;

  assign req_rdy_o  = !pending_q && !stall_q;
  assign rsp_val_o  = pending_q && (delay_q == 2'd0);
  assign rsp_data_o = rdata_q;

  always @(posedge clk_i) begin
    integer rnd;
    if (!rst_ni) begin
      pending_q <= 1'b0;
      stall_q   <= 1'b0;
      delay_q   <= 2'd0;
      rdata_q   <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= 32'hbad0_0000 ^ word_t'(i);
      end
      // one free block covering the whole heap
      mem[HEAD_ADDR[11:2]]       <= HEAP_ADDR;
      mem[HEAP_ADDR[11:2]]       <= HEAP_SIZE;
      mem[HEAP_ADDR[11:2] + 1'b1] <= NULL_PTR;
    end else if (!pending_q) begin
      rnd = $random(seed);
      if (req_val_i && !stall_q) begin
        pending_q <= 1'b1;
        delay_q   <= rnd[1:0];
        if (req_i.is_write) begin
          mem[req_i.addr[11:2]] <= req_i.data;
          rdata_q               <= '0;  // write response has no data
        end else begin
          rdata_q <= mem[req_i.addr[11:2]];
        end
      end else begin
        stall_q <= rnd[2] && !stall_q;  // never two refusals in a row
      end
    end else if (delay_q != 2'd0) begin
      delay_q <= delay_q - 2'd1;
    end else if (rsp_rdy_i) begin
      pending_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
falafel_pkg.sv
falafel_block_parser.sv
falafel_lsu.sv
falafel_core.sv
falafel_top.sv
tb_clock_gen.sv
tb_falafel_mem.sv
falafel_assert.sv
tb_falafel.sv
